// ==== common/regPkg.sv ====
`default_nettype none

package regPkg;

    // Wishbone data and word address
    typedef logic [31:0] wbDataT;
    typedef logic [3:0] wbAddrT;

    // Edge threshold register
    typedef logic [15:0] thresholdT;

    // Completed frame counter, wraps
    localparam int frameCountWidth = 16;
    typedef logic [frameCountWidth-1:0] frameCountT;

    // Register map
    localparam wbAddrT thresholdAddr = 4'd0;
    localparam wbAddrT controlAddr = 4'd1;
    localparam wbAddrT frameCountAddr = 4'd2;

    // Control register fields
    localparam int enableBit = 0;

endpackage

`default_nettype wire

// ==== common/sobelPkg.sv ====
`default_nettype none

package sobelPkg;

    // Largest line the counters and line memories can address
    localparam int maxLineWidth = 1024;

    // Bits per camera sample
    localparam int pixelWidth = 8;

    // Unsigned camera sample
    typedef logic [pixelWidth-1:0] pixelT;

    // Signed Sobel gradient
    // Weighted column sums reach 1020 so 12 bits leave headroom
    typedef logic signed [11:0] gradT;

    // Sum of absolute gradients
    typedef logic [11:0] magT;

    // Column or row index
    typedef logic [$clog2(maxLineWidth)-1:0] coordT;

    // Nine pixels in row-major order
    // Top-left pixel sits in the top bits
    typedef logic [9*pixelWidth-1:0] windowT;

    // Packed edge bits, first bit in the MSB
    typedef logic [31:0] edgeWordT;

endpackage

`default_nettype wire

// ==== dv/sobelTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module sobelTb;

    localparam int lineWidth = 16;
    localparam int frameRows = 8;
    localparam int ackTimeout = 20;
    localparam int wordTimeout = 200;

    logic camClock;
    logic arstN;
    sobelPkg::pixelT pixelData;
    logic pixelValid;
    logic hsync;
    logic vsync;
    logic wbCyc;
    logic wbStb;
    logic wbWe;
    regPkg::wbAddrT wbAddr;
    regPkg::wbDataT wbDataIn;
    regPkg::wbDataT wbDataOut;
    logic wbAck;
    sobelPkg::edgeWordT edgeWord;
    logic edgeWordValid;

    int errors;
    int assertErrors;
    int seedValue;
    int expectedFrames;
    int thresholdSet;
    logic enableSet;
    // Model of the frame FSM, enable as latched at vsync
    logic modelActive;
    regPkg::wbDataT readValue;
    int framePix [frameRows][lineWidth];
    logic [31:0] expectedWords [$];
    logic [31:0] gotWords [$];

    sobelTop #(
        .lineWidth(lineWidth)
    ) sobelTop_inst (
        .camClock(camClock),
        .arstN(arstN),
        .pixelData(pixelData),
        .pixelValid(pixelValid),
        .hsync(hsync),
        .vsync(vsync),
        .wbCyc(wbCyc),
        .wbStb(wbStb),
        .wbWe(wbWe),
        .wbAddr(wbAddr),
        .wbDataIn(wbDataIn),
        .wbDataOut(wbDataOut),
        .wbAck(wbAck),
        .edgeWord(edgeWord),
        .edgeWordValid(edgeWordValid)
    );

    always #20 camClock = ~camClock;

    // Words collected mid-cycle, away from the edge
    always @(negedge camClock) begin
        if (arstN && edgeWordValid) begin
            gotWords.push_back(edgeWord);
        end
    end

    // Inputs change 2 ns after the rising edge
    task automatic nextCycle();
        @(posedge camClock);
        #2;
    endtask

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        assert (got === exp) else begin
            errors++;
            $display("CHECK FAILED %s got 0x%08h expected 0x%08h", name, got, exp);
        end
    endtask

    // One classic cycle, stb dropped once ack is seen
    task automatic wbAccess(input logic we, input regPkg::wbAddrT addr,
                            input regPkg::wbDataT data, output regPkg::wbDataT rdata);
        int waited;
        waited = 0;
        wbCyc = 1'b1;
        wbStb = 1'b1;
        wbWe = we;
        wbAddr = addr;
        wbDataIn = data;
        nextCycle();
        while (!wbAck && waited < ackTimeout) begin
            nextCycle();
            waited++;
        end
        rdata = wbDataOut;
        if (!wbAck) begin
            errors++;
            $display("Timeout waiting for wbAck at address %0d", addr);
        end
        wbCyc = 1'b0;
        wbStb = 1'b0;
        wbWe = 1'b0;
    endtask

    task automatic wbWrite(input regPkg::wbAddrT addr, input regPkg::wbDataT data);
        regPkg::wbDataT unused;
        wbAccess(1'b1, addr, data, unused);
    endtask

    task automatic readCheck(input string name, input regPkg::wbAddrT addr,
                             input regPkg::wbDataT exp);
        wbAccess(1'b0, addr, '0, readValue);
        checkValue(name, readValue, exp);
    endtask

    // Sobel magnitude for the window whose bottom-right pixel is (r, c)
    function automatic int kernelMag(input int r, input int c);
        int gx;
        int gy;
        gx = framePix[r-2][c] + 2 * framePix[r-1][c] + framePix[r][c]
           - framePix[r-2][c-2] - 2 * framePix[r-1][c-2] - framePix[r][c-2];
        gy = framePix[r-2][c-2] + 2 * framePix[r-2][c-1] + framePix[r-2][c]
           - framePix[r][c-2] - 2 * framePix[r][c-1] - framePix[r][c];
        return (gx < 0 ? -gx : gx) + (gy < 0 ? -gy : gy);
    endfunction

    // Full words only, leftover bits die at the next vsync
    function automatic void buildExpected();
        logic [31:0] word;
        int bits;
        word = '0;
        bits = 0;
        expectedWords.delete();
        for (int r = 2; r < frameRows; r++) begin
            for (int c = 2; c < lineWidth; c++) begin
                word = {word[30:0], kernelMag(r, c) > thresholdSet};
                bits++;
                if (bits == 32) begin
                    expectedWords.push_back(word);
                    bits = 0;
                end
            end
        end
    endfunction

    function automatic void fillRandom();
        for (int r = 0; r < frameRows; r++) begin
            for (int c = 0; c < lineWidth; c++) begin
                framePix[r][c] = $urandom % 256;
            end
        end
    endfunction

    // Vertical step halfway across the line
    function automatic void fillStep();
        for (int r = 0; r < frameRows; r++) begin
            for (int c = 0; c < lineWidth; c++) begin
                framePix[r][c] = (c < lineWidth / 2) ? 0 : 200;
            end
        end
    endfunction

    // vsync, then lines split by hsync, then the words are compared
    task automatic runFrame();
        int waited;
        gotWords.delete();
        vsync = 1'b1;
        if (modelActive) begin
            expectedFrames++;
        end
        modelActive = enableSet;
        nextCycle();
        vsync = 1'b0;
        nextCycle();
        for (int r = 0; r < frameRows; r++) begin
            if (r > 0) begin
                hsync = 1'b1;
                nextCycle();
                hsync = 1'b0;
            end
            for (int c = 0; c < lineWidth; c++) begin
                pixelData = sobelPkg::pixelT'(framePix[r][c]);
                pixelValid = 1'b1;
                nextCycle();
            end
            pixelValid = 1'b0;
        end
        if (modelActive) begin
            buildExpected();
        end else begin
            expectedWords.delete();
        end
        waited = 0;
        while (gotWords.size() < expectedWords.size() && waited < wordTimeout) begin
            nextCycle();
            waited++;
        end
        if (gotWords.size() < expectedWords.size()) begin
            errors++;
            $display("Timeout waiting for edgeWordValid");
        end
        // Trailing cycles catch stray words
        repeat (6) nextCycle();
        checkValue("edgeWord count", 32'(gotWords.size()), 32'(expectedWords.size()));
        for (int i = 0; i < gotWords.size() && i < expectedWords.size(); i++) begin
            checkValue("edgeWord", gotWords[i], expectedWords[i]);
        end
    endtask

    initial begin
        seedValue = $urandom(916);
        errors = 0;
        assertErrors = 0;
        expectedFrames = 0;
        thresholdSet = 0;
        enableSet = 1'b0;
        modelActive = 1'b0;
        camClock = 1'b0;
        arstN = 1'b0;
        pixelData = '0;
        pixelValid = 1'b0;
        hsync = 1'b0;
        vsync = 1'b0;
        wbCyc = 1'b0;
        wbStb = 1'b0;
        wbWe = 1'b0;
        wbAddr = '0;
        wbDataIn = '0;
        repeat (10) @(posedge camClock);
        #2;
        arstN = 1'b1;
        nextCycle();
        checkValue("wbAck", 32'(wbAck), 32'h0);
        checkValue("edgeWordValid", 32'(edgeWordValid), 32'h0);

        // Register map
        thresholdSet = 100;
        wbWrite(regPkg::thresholdAddr, 32'(thresholdSet));
        readCheck("threshold", regPkg::thresholdAddr, 32'(thresholdSet));
        enableSet = 1'b1;
        wbWrite(regPkg::controlAddr, 32'h1);
        readCheck("control", regPkg::controlAddr, 32'h1);
        readCheck("unmapped", 4'd7, 32'h0);
        readCheck("unmapped", 4'hF, 32'h0);
        wbWrite(regPkg::frameCountAddr, 32'h55);
        readCheck("frameCount", regPkg::frameCountAddr, 32'h0);

        // Random frame at a mid threshold
        fillRandom();
        runFrame();

        // Step edge seen at threshold 0, nothing at full scale
        thresholdSet = 0;
        wbWrite(regPkg::thresholdAddr, 32'(thresholdSet));
        fillStep();
        runFrame();
        thresholdSet = 32'hFFFF;
        wbWrite(regPkg::thresholdAddr, 32'(thresholdSet));
        runFrame();

        // Disabled frame yields no words
        enableSet = 1'b0;
        wbWrite(regPkg::controlAddr, 32'h0);
        readCheck("control", regPkg::controlAddr, 32'h0);
        fillRandom();
        runFrame();
        readCheck("frameCount", regPkg::frameCountAddr, 32'(expectedFrames));

        repeat (4) nextCycle();
        assertErrors = sobelTop_inst.sobelTopAsserts_inst.failCount;
        $display("Check errors: %0d, assertion errors: %0d", errors, assertErrors);
        if (errors == 0 && assertErrors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== dv/sobelTop_asserts.sv ====
`timescale 1ns/1ps
`default_nettype none

module sobelTopAsserts (
    input wire camClock,
    input wire arstN,
    input wire wbCyc,
    input wire wbStb,
    input wire wbAck,
    input wire vsync,
    input wire enable,
    input wire pixelAccept,
    input wire edgeWordValid
);

    // Enable as the frame FSM latched it at the last vsync
    logic frameEnabled;
    int failCount = 0;

    always_ff @(posedge camClock or negedge arstN) begin
        if (!arstN) begin
            frameEnabled <= 1'b0;
        end else if (vsync) begin
            frameEnabled <= enable;
        end
    end

    // Ack only answers a pending request
    ackFollowsRequest: assert property (@(posedge camClock) disable iff (!arstN)
        wbAck |-> $past(wbCyc && wbStb && !wbAck))
        else begin
            failCount++;
            $error("wbAck without a preceding request");
        end

    ackSinglePulse: assert property (@(posedge camClock) disable iff (!arstN)
        wbAck |=> !wbAck)
        else begin
            failCount++;
            $error("wbAck longer than one cycle");
        end

    wordSinglePulse: assert property (@(posedge camClock) disable iff (!arstN)
        edgeWordValid |=> !edgeWordValid)
        else begin
            failCount++;
            $error("edgeWordValid in two consecutive cycles");
        end

    // Pixel to word takes three edges
    wordFromPixel: assert property (@(posedge camClock) disable iff (!arstN)
        edgeWordValid |-> $past(pixelAccept, 3))
        else begin
            failCount++;
            $error("edgeWordValid without an accepted pixel three cycles earlier");
        end

    // No words while the latched enable is low
    quietWhenDisabled: assert property (@(posedge camClock) disable iff (!arstN)
        !frameEnabled |-> !edgeWordValid)
        else begin
            failCount++;
            $error("edgeWordValid in a disabled frame");
        end

endmodule

bind sobelTop sobelTopAsserts sobelTopAsserts_inst (
    .camClock(camClock),
    .arstN(arstN),
    .wbCyc(wbCyc),
    .wbStb(wbStb),
    .wbAck(wbAck),
    .vsync(vsync),
    .enable(enable),
    .pixelAccept(pixelAccept),
    .edgeWordValid(edgeWordValid)
);

`default_nettype wire

// ==== logic/configRegs.sv ====
`timescale 1ns/1ps
`default_nettype none

module configRegs (
    input  wire                camClock,
    input  wire                arstN,
    input  wire                wbCyc,
    input  wire                wbStb,
    input  wire                wbWe,
    input  wire regPkg::wbAddrT wbAddr,
    input  wire regPkg::wbDataT wbDataIn,
    input  wire                frameDone,
    output regPkg::wbDataT     wbDataOut,
    output logic               wbAck,
    output regPkg::thresholdT  threshold,
    output logic               enable
);

    logic request;
    regPkg::frameCountT frameCount;
    regPkg::wbDataT readData;

    // New request only while no ack is outstanding
    assign request = wbCyc & wbStb & ~wbAck;

    // Read mux, unmapped addresses read zero
    always_comb begin
        readData = '0;
        case (wbAddr)
            regPkg::thresholdAddr: begin
                readData = regPkg::wbDataT'(threshold);
            end
            regPkg::controlAddr: begin
                readData[regPkg::enableBit] = enable;
            end
            regPkg::frameCountAddr: begin
                readData = regPkg::wbDataT'(frameCount);
            end
            default: begin
                readData = '0;
            end
        endcase
    end

    always_ff @(posedge camClock or negedge arstN) begin
        if (!arstN) begin
            wbAck <= 1'b0;
            threshold <= '0;
            enable <= 1'b0;
            frameCount <= '0;
        end else begin
            // Single-cycle ack on the edge after the request
            wbAck <= request;
            if (request && wbWe) begin
                case (wbAddr)
                    regPkg::thresholdAddr: begin
                        threshold <= regPkg::thresholdT'(wbDataIn);
                    end
                    regPkg::controlAddr: begin
                        enable <= wbDataIn[regPkg::enableBit];
                    end
                    // Frame count is read-only
                    default: begin
                    end
                endcase
            end
            if (frameDone) begin
                frameCount <= frameCount + regPkg::frameCountT'(1);
            end
        end
    end

    // Read data lines up with the ack cycle
    always_ff @(posedge camClock) begin
        if (request) begin
            wbDataOut <= readData;
        end
    end

endmodule

`default_nettype wire

// ==== logic/frameControl.sv ====
`timescale 1ns/1ps
`default_nettype none

module frameControl #(
    parameter int lineWidth = 640
) (
    input  wire             camClock,
    input  wire             arstN,
    input  wire             pixelValid,
    input  wire             hsync,
    input  wire             vsync,
    input  wire             enable,
    output logic            pixelAccept,
    output sobelPkg::coordT column,
    output logic            windowValid,
    output logic            lineStart,
    output logic            frameStart,
    output logic            frameDone
);

    typedef enum logic {
        waitFrame,
        active
    } stateT;

    // Index of the last legal pixel in a line
    localparam sobelPkg::coordT lastColumn = sobelPkg::coordT'(lineWidth - 1);

    stateT state;
    sobelPkg::coordT row;
    logic lineFull;
    logic hsyncPrev;
    logic vsyncPrev;
    logic hsyncRise;
    logic vsyncRise;

    // Edge detect so long sync pulses count once
    assign hsyncRise = hsync & ~hsyncPrev;
    assign vsyncRise = vsync & ~vsyncPrev;

    // Pixels during sync or past the line end are dropped
    assign pixelAccept = pixelValid & (state == active) & ~hsync & ~vsync & ~lineFull;

    // Full 3x3 neighbourhood once two columns and two rows are behind us
    assign windowValid = pixelAccept
                       & (column >= sobelPkg::coordT'(2))
                       & (row >= sobelPkg::coordT'(2));

    // Any sync restarts the window
    assign lineStart = hsync | vsync;
    assign frameStart = vsync;

    always_ff @(posedge camClock or negedge arstN) begin
        if (!arstN) begin
            state <= waitFrame;
            column <= '0;
            row <= '0;
            lineFull <= 1'b0;
            hsyncPrev <= 1'b0;
            vsyncPrev <= 1'b0;
            frameDone <= 1'b0;
        end else begin
            hsyncPrev <= hsync;
            vsyncPrev <= vsync;
            // One pulse per vsync that closes a processed frame
            frameDone <= vsyncRise & (state == active);
            if (vsync) begin
                // Enable only takes effect at frame start
                state <= enable ? active : waitFrame;
                column <= '0;
                row <= '0;
                lineFull <= 1'b0;
            end else if (hsync) begin
                // hsync ends a line
                column <= '0;
                lineFull <= 1'b0;
                if (hsyncRise && row != '1) begin
                    row <= row + sobelPkg::coordT'(1);
                end
            end else if (pixelAccept) begin
                if (column == lastColumn) begin
                    lineFull <= 1'b1;
                end else begin
                    column <= column + sobelPkg::coordT'(1);
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/sobelTop.sv ====
`timescale 1ns/1ps
`default_nettype none

module sobelTop #(
    parameter int lineWidth = 640
) (
    input  wire                  camClock,
    input  wire                  arstN,
    input  wire sobelPkg::pixelT pixelData,
    input  wire                  pixelValid,
    input  wire                  hsync,
    input  wire                  vsync,
    input  wire                  wbCyc,
    input  wire                  wbStb,
    input  wire                  wbWe,
    input  wire regPkg::wbAddrT  wbAddr,
    input  wire regPkg::wbDataT  wbDataIn,
    output regPkg::wbDataT       wbDataOut,
    output logic                 wbAck,
    output sobelPkg::edgeWordT   edgeWord,
    output logic                 edgeWordValid
);

    // Control strobes
    logic pixelAccept;
    sobelPkg::coordT column;
    logic windowValid;
    logic lineStart;
    logic frameStart;
    logic frameDone;

    // Configuration
    regPkg::thresholdT threshold;
    logic enable;

    // Datapath
    sobelPkg::windowT window;
    logic edgeBit;
    logic edgeValid;

    frameControl #(
        .lineWidth(lineWidth)
    ) frameControl_inst (
        .camClock(camClock),
        .arstN(arstN),
        .pixelValid(pixelValid),
        .hsync(hsync),
        .vsync(vsync),
        .enable(enable),
        .pixelAccept(pixelAccept),
        .column(column),
        .windowValid(windowValid),
        .lineStart(lineStart),
        .frameStart(frameStart),
        .frameDone(frameDone)
    );

    configRegs configRegs_inst (
        .camClock(camClock),
        .arstN(arstN),
        .wbCyc(wbCyc),
        .wbStb(wbStb),
        .wbWe(wbWe),
        .wbAddr(wbAddr),
        .wbDataIn(wbDataIn),
        .frameDone(frameDone),
        .wbDataOut(wbDataOut),
        .wbAck(wbAck),
        .threshold(threshold),
        .enable(enable)
    );

    lineWindow #(
        .lineWidth(lineWidth)
    ) lineWindow_inst (
        .camClock(camClock),
        .arstN(arstN),
        .pixelData(pixelData),
        .pixelAccept(pixelAccept),
        .column(column),
        .lineStart(lineStart),
        .window(window)
    );

    sobelKernel sobelKernel_inst (
        .camClock(camClock),
        .arstN(arstN),
        .window(window),
        .windowValid(windowValid),
        .threshold(threshold),
        .edgeBit(edgeBit),
        .edgeValid(edgeValid)
    );

    edgePacker edgePacker_inst (
        .camClock(camClock),
        .arstN(arstN),
        .edgeBit(edgeBit),
        .edgeValid(edgeValid),
        .frameStart(frameStart),
        .edgeWord(edgeWord),
        .edgeWordValid(edgeWordValid)
    );

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# Build and run the Sobel testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module sobelTb \
    -f sobelTop.f -o sobelSim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

simOutput=$(./obj_dir/sobelSim +verilator+error+limit+1000)
simStatus=$?
echo "$simOutput"
if [ $simStatus -ne 0 ]; then
    echo "Simulation exited with status $simStatus"
    exit 1
fi

if echo "$simOutput" | grep -qx "No errors"; then
    exit 0
fi
echo "Simulation reported failures"
exit 1

// ==== sobel/edgePacker.sv ====
`timescale 1ns/1ps
`default_nettype none

module edgePacker (
    input  wire                camClock,
    input  wire                arstN,
    input  wire                edgeBit,
    input  wire                edgeValid,
    input  wire                frameStart,
    output sobelPkg::edgeWordT edgeWord,
    output logic               edgeWordValid
);

    localparam int wordBits = $bits(sobelPkg::edgeWordT);
    localparam int countWidth = $clog2(wordBits);

    logic [countWidth-1:0] bitCount;

    always_ff @(posedge camClock or negedge arstN) begin
        if (!arstN) begin
            edgeWord <= '0;
            bitCount <= '0;
            edgeWordValid <= 1'b0;
        end else begin
            edgeWordValid <= 1'b0;
            if (frameStart) begin
                // Partial word of the old frame is dropped
                edgeWord <= '0;
                bitCount <= '0;
            end else if (edgeValid) begin
                // First bit ends up in the MSB
                edgeWord <= {edgeWord[wordBits-2:0], edgeBit};
                bitCount <= bitCount + countWidth'(1);
                // Count wraps on the last bit of a word
                edgeWordValid <= (bitCount == '1);
            end
        end
    end

endmodule

`default_nettype wire

// ==== sobel/lineWindow.sv ====
`timescale 1ns/1ps
`default_nettype none

module lineWindow #(
    parameter int lineWidth = 640
) (
    input  wire                  camClock,
    input  wire                  arstN,
    input  wire sobelPkg::pixelT pixelData,
    input  wire                  pixelAccept,
    input  wire sobelPkg::coordT column,
    input  wire                  lineStart,
    output sobelPkg::windowT     window
);

    localparam int addrWidth = $clog2(lineWidth);
    localparam int pw = sobelPkg::pixelWidth;

    // Previous line and the one before it
    sobelPkg::pixelT rowNewer [lineWidth];
    sobelPkg::pixelT rowOlder [lineWidth];

    logic [addrWidth-1:0] addr;
    sobelPkg::pixelT topPixel;
    sobelPkg::pixelT midPixel;

    assign addr = column[addrWidth-1:0];

    // Asynchronous read so the column lands on the accepting edge
    assign topPixel = rowOlder[addr];
    assign midPixel = rowNewer[addr];

    // Newest pixel goes in, previous line value moves down one memory
    always_ff @(posedge camClock) begin
        if (pixelAccept) begin
            rowNewer[addr] <= pixelData;
            rowOlder[addr] <= midPixel;
        end
    end

    // Window shifts left one column per pixel
    // Each row is left, middle, right with left in the top bits
    always_ff @(posedge camClock or negedge arstN) begin
        if (!arstN) begin
            window <= '0;
        end else if (lineStart) begin
            // No pixels carried across lines
            window <= '0;
        end else if (pixelAccept) begin
            window <= {
                window[8*pw-1 -: 2*pw], topPixel,
                window[5*pw-1 -: 2*pw], midPixel,
                window[2*pw-1 -: 2*pw], pixelData
            };
        end
    end

endmodule

`default_nettype wire

// ==== sobel/sobelKernel.sv ====
`timescale 1ns/1ps
`default_nettype none

module sobelKernel (
    input  wire                     camClock,
    input  wire                     arstN,
    input  wire sobelPkg::windowT   window,
    input  wire                     windowValid,
    input  wire regPkg::thresholdT  threshold,
    output logic                    edgeBit,
    output logic                    edgeValid
);

    localparam int pw = sobelPkg::pixelWidth;

    // 1-2-1 weighted sum of three pixels
    function automatic sobelPkg::magT weightSum(
        input sobelPkg::pixelT a,
        input sobelPkg::pixelT b,
        input sobelPkg::pixelT c
    );
        return sobelPkg::magT'(a) + (sobelPkg::magT'(b) << 1) + sobelPkg::magT'(c);
    endfunction

    function automatic sobelPkg::magT absGrad(input sobelPkg::gradT g);
        return g[$bits(g)-1] ? sobelPkg::magT'(-g) : sobelPkg::magT'(g);
    endfunction

    // p[0] top-left through p[8] bottom-right
    sobelPkg::pixelT p [9];
    sobelPkg::gradT gx;
    sobelPkg::gradT gy;
    sobelPkg::magT magnitude;
    logic windowValidQ;

    always_comb begin
        for (int i = 0; i < 9; i++) begin
            p[i] = window[9*pw-1-pw*i -: pw];
        end
    end

    // Right column minus left column
    assign gx = sobelPkg::gradT'(weightSum(p[2], p[5], p[8]))
              - sobelPkg::gradT'(weightSum(p[0], p[3], p[6]));

    // Top row minus bottom row
    assign gy = sobelPkg::gradT'(weightSum(p[0], p[1], p[2]))
              - sobelPkg::gradT'(weightSum(p[6], p[7], p[8]));

    assign magnitude = absGrad(gx) + absGrad(gy);

    always_ff @(posedge camClock or negedge arstN) begin
        if (!arstN) begin
            windowValidQ <= 1'b0;
            edgeValid <= 1'b0;
            edgeBit <= 1'b0;
        end else begin
            // Window lands one edge after windowValid
            windowValidQ <= windowValid;
            edgeValid <= windowValidQ;
            // Strictly greater than threshold
            edgeBit <= regPkg::thresholdT'(magnitude) > threshold;
        end
    end

endmodule

`default_nettype wire

// ==== sobelTop.f ====
common/sobelPkg.sv
common/regPkg.sv
logic/frameControl.sv
logic/configRegs.sv
sobel/lineWindow.sv
sobel/sobelKernel.sv
sobel/edgePacker.sv
logic/sobelTop.sv
dv/sobelTop_asserts.sv
dv/sobelTb.sv
